// ==== ps2_lcd_pkg.sv ====
package ps2_lcd_pkg;

   // --------------------
   // Widths
   localparam int SCAN_W = 8;             // PS/2 scan code
   localparam int CHAR_W = 8;             // LCD character or command byte
   localparam int POS_W  = 5;             // 32 screen positions

   // --------------------
   // Screen layout
   localparam int LINE_LEN   = 16;        // Characters per line
   localparam int SCREEN_LEN = 2 * LINE_LEN;
   localparam int KEY_POS    = 8;         // Live key on line 1
   localparam logic [CHAR_W-1:0] CHAR_SPACE = 8'h20;

   // --------------------
   // HD44780 command bytes
   localparam logic [CHAR_W-1:0] CMD_FUNC_SET    = 8'h38;   // 8 bit bus, 2 lines, 5x8
   localparam logic [CHAR_W-1:0] CMD_DISPLAY_OFF = 8'h08;
   localparam logic [CHAR_W-1:0] CMD_CLEAR       = 8'h01;
   localparam logic [CHAR_W-1:0] CMD_DISPLAY_ON  = 8'h0C;   // Cursor off
   localparam logic [CHAR_W-1:0] CMD_ENTRY_MODE  = 8'h06;   // Auto increment
   localparam logic [CHAR_W-1:0] CMD_LINE2       = 8'hC0;   // DDRAM 40h
   localparam logic [CHAR_W-1:0] CMD_HOME        = 8'h80;   // DDRAM 00h

   localparam int INIT_FUNC_SETS = 4;     // Repeated for a reliable start

   // Sequencer states
   typedef enum logic [3:0] {
      ST_FUNC_SET,
      ST_DISPLAY_OFF,
      ST_CLEAR,
      ST_DISPLAY_ON,
      ST_ENTRY_MODE,
      ST_PRINT,                           // One data byte
      ST_LINE2,
      ST_HOME,
      ST_DROP_EN,                         // Falling edge of E latches byte
      ST_HOLD                             // Keep byte valid after the edge
   } lcd_state_t;

endpackage

// ==== ps2_receiver.sv ====
`timescale 1ns/10ps
module ps2_receiver #(
   parameter int FILTER_LEN = 8
) (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic                           ps2_clk,
   input  logic                           ps2_data,
   input  logic                           key_ack,
   output logic                           key_req,
   output logic [ps2_lcd_pkg::SCAN_W-1:0] scan_code
);
   import ps2_lcd_pkg::*;

   localparam int CNT_W    = $clog2(SCAN_W + 2);
   localparam int STOP_IDX = SCAN_W + 1;  // Parity sits at SCAN_W

   logic [FILTER_LEN-1:0] clk_filter;     // Raw PS/2 clock history
   logic                  clk_filt;
   logic                  clk_filt_d;
   logic                  clk_fall;
   logic                  in_frame;       // Start bit seen
   logic [CNT_W-1:0]      bit_cnt;
   logic [SCAN_W-1:0]     shift_in;
   logic                  stop_edge;
   logic                  load_code;

   // --------------------
   // Clock filter
   always_ff @(posedge clock or negedge iRST_N)
   begin
      if (!iRST_N)
      begin
         clk_filter <= '1;                // Line idles high
         clk_filt   <= 1'b1;
         clk_filt_d <= 1'b1;
      end
      else
      begin
         clk_filter <= {ps2_clk, clk_filter[FILTER_LEN-1:1]};
         if (clk_filter == '1)
            clk_filt <= 1'b1;
         else if (clk_filter == '0)
            clk_filt <= 1'b0;             // Otherwise keep last level
         clk_filt_d <= clk_filt;
      end
   end

   assign clk_fall  = clk_filt_d & ~clk_filt;
   assign stop_edge = clk_fall & in_frame & (bit_cnt == CNT_W'(STOP_IDX));
   assign load_code = stop_edge & ~key_req & ~key_ack;  // Drop frame if handshake open

   // --------------------
   // Frame control and handshake
   always_ff @(posedge clock or negedge iRST_N)
   begin
      if (!iRST_N)
      begin
         in_frame <= 1'b0;
         bit_cnt  <= '0;
         key_req  <= 1'b0;
      end
      else
      begin
         if (key_req && key_ack)
            key_req <= 1'b0;              // Decoder has taken the code
         if (clk_fall)
         begin
            if (!in_frame)
            begin
               if (!ps2_data)             // Start bit
               begin
                  in_frame <= 1'b1;
                  bit_cnt  <= '0;
               end
            end
            else if (stop_edge)
               in_frame <= 1'b0;          // Stop bit not checked
            else
               bit_cnt <= bit_cnt + 1'b1; // Data and parity
         end
         if (load_code)
            key_req <= 1'b1;
      end
   end

   // Data path, LSB first
   always_ff @(posedge clock)
   begin
      if (clk_fall && in_frame && (bit_cnt < CNT_W'(SCAN_W)))
         shift_in <= {ps2_data, shift_in[SCAN_W-1:1]};
      if (load_code)
         scan_code <= shift_in;
   end

endmodule

// ==== scan_decoder.sv ====
`timescale 1ns/10ps
module scan_decoder (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic                           key_req,
   input  logic [ps2_lcd_pkg::SCAN_W-1:0] scan_code,
   output logic                           key_ack,
   output logic [ps2_lcd_pkg::CHAR_W-1:0] key_char
);
   import ps2_lcd_pkg::*;

   // Set 2 make code to ASCII, unknown gives 00h
   function automatic logic [CHAR_W-1:0] scan_to_ascii(input logic [SCAN_W-1:0] code);
      logic [CHAR_W-1:0] asc;
      case (code)
         // Letters
         8'h1C: asc = 8'h41;  8'h32: asc = 8'h42;  8'h21: asc = 8'h43;
         8'h23: asc = 8'h44;  8'h24: asc = 8'h45;  8'h2B: asc = 8'h46;
         8'h34: asc = 8'h47;  8'h33: asc = 8'h48;  8'h43: asc = 8'h49;
         8'h3B: asc = 8'h4A;  8'h42: asc = 8'h4B;  8'h4B: asc = 8'h4C;
         8'h3A: asc = 8'h4D;  8'h31: asc = 8'h4E;  8'h44: asc = 8'h4F;
         8'h4D: asc = 8'h50;  8'h15: asc = 8'h51;  8'h2D: asc = 8'h52;
         8'h1B: asc = 8'h53;  8'h2C: asc = 8'h54;  8'h3C: asc = 8'h55;
         8'h2A: asc = 8'h56;  8'h1D: asc = 8'h57;  8'h22: asc = 8'h58;
         8'h35: asc = 8'h59;  8'h1A: asc = 8'h5A;
         // Top row digits
         8'h45: asc = 8'h30;  8'h16: asc = 8'h31;  8'h1E: asc = 8'h32;
         8'h26: asc = 8'h33;  8'h25: asc = 8'h34;  8'h2E: asc = 8'h35;
         8'h36: asc = 8'h36;  8'h3D: asc = 8'h37;  8'h3E: asc = 8'h38;
         8'h46: asc = 8'h39;
         // Keypad digits
         8'h70: asc = 8'h30;  8'h69: asc = 8'h31;  8'h72: asc = 8'h32;
         8'h7A: asc = 8'h33;  8'h6B: asc = 8'h34;  8'h73: asc = 8'h35;
         8'h74: asc = 8'h36;  8'h6C: asc = 8'h37;  8'h75: asc = 8'h38;
         8'h7D: asc = 8'h39;
         default: asc = 8'h00;            // Break prefix F0 lands here too
      endcase
      return asc;
   endfunction

   // --------------------
   // Handshake follower
   always_ff @(posedge clock or negedge iRST_N)
   begin
      if (!iRST_N)
      begin
         key_ack  <= 1'b0;
         key_char <= '0;
      end
      else
      begin
         key_ack <= key_req;              // Rises and falls one cycle behind req
         if (key_req && !key_ack)         // Acceptance cycle
            key_char <= scan_to_ascii(scan_code);
      end
   end

endmodule

// ==== lcd_screen_text.sv ====
`timescale 1ns/10ps
module lcd_screen_text (
   input  logic [ps2_lcd_pkg::POS_W-1:0]  char_pos,
   input  logic [ps2_lcd_pkg::CHAR_W-1:0] key_char,
   output logic [ps2_lcd_pkg::CHAR_W-1:0] screen_char
);
   import ps2_lcd_pkg::*;

   logic              second_line;
   logic [POS_W-1:0]  col;
   logic [CHAR_W-1:0] key_shown;

   assign second_line = (char_pos >= POS_W'(LINE_LEN));
   assign col         = second_line ? char_pos - POS_W'(LINE_LEN) : char_pos;

   // Small values become a hex digit
   always_comb
   begin
      if (key_char[7:4] != 4'h0)
         key_shown = key_char;
      else if (key_char[3:0] > 4'd9)
         key_shown = {4'h4, key_char[3:0] - 4'd9};   // 'A'..'F'
      else
         key_shown = {4'h3, key_char[3:0]};          // '0'..'9'
   end

   always_comb
   begin
      screen_char = CHAR_SPACE;
      if (char_pos == POS_W'(KEY_POS))
         screen_char = key_shown;
      else if (!second_line)
         case (col)
            5'd0: screen_char = 8'h50;    // P
            5'd1: screen_char = 8'h53;    // S
            5'd2: screen_char = 8'h32;    // 2
            5'd4: screen_char = 8'h4B;    // K
            5'd5: screen_char = 8'h45;    // E
            5'd6: screen_char = 8'h59;    // Y
            5'd7: screen_char = 8'h3D;    // =
            default: screen_char = CHAR_SPACE;
         endcase
      else
         case (col)
            5'd0: screen_char = 8'h50;    // P
            5'd1: screen_char = 8'h53;    // S
            5'd2: screen_char = 8'h32;    // 2
            5'd3: screen_char = 8'h2B;    // +
            5'd4: screen_char = 8'h4C;    // L
            5'd5: screen_char = 8'h43;    // C
            5'd6: screen_char = 8'h44;    // D
            default: screen_char = CHAR_SPACE;
         endcase
   end

endmodule

// ==== lcd_sequencer.sv ====
`timescale 1ns/10ps
module lcd_sequencer #(
   parameter int TICK_DIV = 12
) (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic [ps2_lcd_pkg::CHAR_W-1:0] screen_char,
   output logic [ps2_lcd_pkg::POS_W-1:0]  char_pos,
   output logic                           lcd_en,
   output logic                           lcd_rs,
   output logic [ps2_lcd_pkg::CHAR_W-1:0] lcd_data
);
   import ps2_lcd_pkg::*;

   localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   localparam int FUNC_W = $clog2(INIT_FUNC_SETS + 1);

   logic [TICK_W-1:0] tick_cnt;
   logic              step;               // One strobe per LCD step
   lcd_state_t        state;
   lcd_state_t        next_cmd;           // Where to go after HOLD
   logic [FUNC_W-1:0] func_cnt;
   logic [CHAR_W-1:0] cmd_byte;
   logic              cmd_rs;
   lcd_state_t        cmd_next;

   // --------------------
   // Step timer
   always_ff @(posedge clock or negedge iRST_N)
   begin
      if (!iRST_N)
         tick_cnt <= '0;
      else if (step)
         tick_cnt <= '0;
      else
         tick_cnt <= tick_cnt + 1'b1;
   end

   assign step = (tick_cnt == TICK_W'(TICK_DIV - 1));

   // Byte, rs and follow-on state for the current transfer
   always_comb
   begin
      cmd_byte = screen_char;
      cmd_rs   = 1'b0;
      cmd_next = ST_PRINT;
      case (state)
         ST_FUNC_SET:
         begin
            cmd_byte = CMD_FUNC_SET;
            cmd_next = (func_cnt == FUNC_W'(INIT_FUNC_SETS - 1)) ? ST_DISPLAY_OFF : ST_FUNC_SET;
         end
         ST_DISPLAY_OFF: begin cmd_byte = CMD_DISPLAY_OFF; cmd_next = ST_CLEAR; end
         ST_CLEAR:       begin cmd_byte = CMD_CLEAR;       cmd_next = ST_DISPLAY_ON; end
         ST_DISPLAY_ON:  begin cmd_byte = CMD_DISPLAY_ON;  cmd_next = ST_ENTRY_MODE; end
         ST_ENTRY_MODE:  cmd_byte = CMD_ENTRY_MODE;
         ST_LINE2:       cmd_byte = CMD_LINE2;
         ST_HOME:        cmd_byte = CMD_HOME;
         ST_PRINT:
         begin
            cmd_rs = 1'b1;                // Character data
            if (char_pos == POS_W'(LINE_LEN - 1))
               cmd_next = ST_LINE2;
            else if (char_pos == POS_W'(SCREEN_LEN - 1))
               cmd_next = ST_HOME;
         end
         default: cmd_next = ST_PRINT;    // DROP_EN and HOLD unused here
      endcase
   end

   // --------------------
   // Transfer FSM
   always_ff @(posedge clock or negedge iRST_N)
   begin
      if (!iRST_N)
      begin
         state    <= ST_FUNC_SET;
         next_cmd <= ST_FUNC_SET;
         func_cnt <= '0;
         char_pos <= '0;
         lcd_en   <= 1'b0;
         lcd_rs   <= 1'b0;
         lcd_data <= '0;
      end
      else if (step)
         case (state)
            ST_DROP_EN:
            begin
               lcd_en <= 1'b0;            // LCD latches here
               state  <= ST_HOLD;
            end
            ST_HOLD: state <= next_cmd;
            default:
            begin
               lcd_en   <= 1'b1;          // Step 1 of every transfer
               lcd_rs   <= cmd_rs;
               lcd_data <= cmd_byte;
               next_cmd <= cmd_next;
               state    <= ST_DROP_EN;
               if (state == ST_FUNC_SET)
                  func_cnt <= func_cnt + 1'b1;
               if (state == ST_PRINT)     // Wraps after position 31
                  char_pos <= (char_pos == POS_W'(SCREEN_LEN - 1)) ? '0 : char_pos + 1'b1;
            end
         endcase
   end

endmodule

// ==== ps2_lcd_top.sv ====
`timescale 1ns/10ps
module ps2_lcd_top #(
   parameter int TICK_DIV   = 12,       // 62500 at 50 MHz on the board
   parameter int FILTER_LEN = 8
) (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic                           ps2_clk,
   input  logic                           ps2_data,
   output logic                           lcd_en,
   output logic                           lcd_rs,
   output logic [ps2_lcd_pkg::CHAR_W-1:0] lcd_data
);
   import ps2_lcd_pkg::*;

   logic              key_req;
   logic              key_ack;
   logic [SCAN_W-1:0] scan_code;
   logic [CHAR_W-1:0] key_char;           // Latest decoded key
   logic [POS_W-1:0]  char_pos;
   logic [CHAR_W-1:0] screen_char;

   // --------------------
   // Keyboard side
   ps2_receiver #(.FILTER_LEN(FILTER_LEN)) i_ps2_receiver (
      .clock(clock), .iRST_N(iRST_N), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .key_ack(key_ack), .key_req(key_req), .scan_code(scan_code));

   scan_decoder i_scan_decoder (
      .clock(clock), .iRST_N(iRST_N), .key_req(key_req), .scan_code(scan_code),
      .key_ack(key_ack), .key_char(key_char));

   // --------------------
   // LCD side
   lcd_screen_text i_lcd_screen_text (
      .char_pos(char_pos), .key_char(key_char), .screen_char(screen_char));

   lcd_sequencer #(.TICK_DIV(TICK_DIV)) i_lcd_sequencer (
      .clock(clock), .iRST_N(iRST_N), .screen_char(screen_char), .char_pos(char_pos),
      .lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_data(lcd_data));

endmodule

// ==== ps2_lcd_asserts.sv ====
`timescale 1ns/10ps
module ps2_lcd_asserts (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic                           key_req,
   input  logic                           key_ack,
   input  logic [ps2_lcd_pkg::SCAN_W-1:0] scan_code,
   input  logic                           lcd_en,
   input  logic                           lcd_rs,
   input  logic [ps2_lcd_pkg::CHAR_W-1:0] lcd_data,
   input  ps2_lcd_pkg::lcd_state_t        seq_state
);
   import ps2_lcd_pkg::*;

   int fail_count = 0;                    // Failed assertions so far

   // --------------------
   // Receiver to decoder handshake
   req_held: assert property (@(posedge clock) disable iff (!iRST_N)
      key_req && !key_ack |=> key_req)
   else
   begin
      fail_count++;
      $error("key_req dropped before key_ack was seen");
   end

   code_stable: assert property (@(posedge clock) disable iff (!iRST_N)
      key_req |=> !key_req || $stable(scan_code))
   else
   begin
      fail_count++;
      $error("scan_code changed while key_req was high");
   end

   ack_follows_req: assert property (@(posedge clock) disable iff (!iRST_N)
      !key_req |=> !key_ack)
   else
   begin
      fail_count++;
      $error("key_ack rose while key_req was low");
   end

   // --------------------
   // LCD pins
   data_stable: assert property (@(posedge clock) disable iff (!iRST_N)
      lcd_en |=> !lcd_en || $stable(lcd_data))
   else
   begin
      fail_count++;
      $error("lcd_data changed while lcd_en was high");
   end

   // --------------------
   // Sequencer order
   data_then_display: assert property (@(posedge clock) disable iff (!iRST_N)
      seq_state == ST_HOLD && lcd_rs |=>
         seq_state inside {ST_HOLD, ST_PRINT, ST_LINE2, ST_HOME})   // Stay in display loop
   else
   begin
      fail_count++;
      $error("Sequencer left the display loop after a data byte");
   end

endmodule

// ==== ps2_lcd_checker.sv ====
`timescale 1ns/10ps
module ps2_lcd_checker #(
   parameter int TICK_DIV = 12
) (
   input  logic                           clock,
   input  logic                           iRST_N,
   input  logic                           ps2_clk,
   input  logic                           ps2_data,
   input  logic                           lcd_en,
   input  logic                           lcd_rs,
   input  logic [ps2_lcd_pkg::CHAR_W-1:0] lcd_data,
   output int                             error_count,
   output int                             bytes_checked,
   output int                             keys_seen
);
   import ps2_lcd_pkg::*;

   localparam int INIT_LEN    = INIT_FUNC_SETS + 4;
   localparam int REFRESH_LEN = SCREEN_LEN + 2;       // 32 chars, LINE2, HOME
   localparam int STALL_LIMIT = 4 * 3 * TICK_DIV;     // Four transfers without a strobe
   localparam logic [8*LINE_LEN-1:0] LINE1_TEXT = "PS2 KEY=        ";
   localparam logic [8*LINE_LEN-1:0] LINE2_TEXT = "PS2+LCD         ";

   // Set 2 make codes, in ASCII order
   logic [SCAN_W-1:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
      8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
      8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
   logic [SCAN_W-1:0] top_digits [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
      8'h36, 8'h3D, 8'h3E, 8'h46};
   logic [SCAN_W-1:0] pad_digits [10] = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73,
      8'h74, 8'h6C, 8'h75, 8'h7D};
   logic [CHAR_W-1:0] init_tail [4] = '{CMD_DISPLAY_OFF, CMD_CLEAR, CMD_DISPLAY_ON,
      CMD_ENTRY_MODE};

   int                ps2_cnt = 0;        // 0 idle, 1..8 data, 9 parity, 10 stop
   logic [SCAN_W-1:0] ps2_code;
   logic [SCAN_W-1:0] last_code;
   int                key_total = 0;
   int                keys_used = 0;      // Keys already folded into the model
   int                byte_idx = 0;       // Position in the LCD byte stream
   int                byte_total = 0;
   int                byte_errors = 0;
   int                stall_errors = 0;
   int                idle_cycles = 0;
   logic              en_d = 1'b0;
   logic [CHAR_W-1:0] shown_key = 8'h30;  // key_char 00h shows as '0'
   logic [CHAR_W-1:0] old_key = 8'h30;
   logic              allow_old = 1'b0;   // One stale KEY_POS write allowed

   assign error_count   = byte_errors + stall_errors;
   assign bytes_checked = byte_total;
   assign keys_seen     = key_total;

   // Scan code to displayed character
   function automatic logic [CHAR_W-1:0] expected_key(input logic [SCAN_W-1:0] code);
      logic [CHAR_W-1:0] asc;
      asc = 8'h00;                        // Unknown key
      for (int i = 0; i < 26; i++)
         if (letter_codes[i] == code)
            asc = CHAR_W'(8'h41 + i);
      for (int i = 0; i < 10; i++)
         if (top_digits[i] == code || pad_digits[i] == code)
            asc = CHAR_W'(8'h30 + i);
      if (asc[7:4] == 4'h0)               // Small values shown as hex digit
         asc = (asc[3:0] > 4'd9) ? CHAR_W'(8'h37 + asc[3:0]) : CHAR_W'(8'h30 + asc[3:0]);
      return asc;
   endfunction

   // {rs, byte} expected at stream index idx
   function automatic logic [CHAR_W:0] expected_byte(input int idx,
                                                     input logic [CHAR_W-1:0] key);
      logic [CHAR_W:0] rs_byte;
      int              slot;
      int              pos;
      slot = (idx - INIT_LEN) % REFRESH_LEN;
      pos  = (slot > LINE_LEN) ? slot - 1 : slot;   // Skip the LINE2 slot
      if (idx < INIT_FUNC_SETS)
         rs_byte = {1'b0, CMD_FUNC_SET};
      else if (idx < INIT_LEN)
         rs_byte = {1'b0, init_tail[idx - INIT_FUNC_SETS]};
      else if (slot == LINE_LEN)
         rs_byte = {1'b0, CMD_LINE2};
      else if (slot == REFRESH_LEN - 1)
         rs_byte = {1'b0, CMD_HOME};
      else if (pos == KEY_POS)
         rs_byte = {1'b1, key};
      else if (pos < LINE_LEN)
         rs_byte = {1'b1, LINE1_TEXT[8 * (LINE_LEN - 1 - pos) +: 8]};
      else
         rs_byte = {1'b1, LINE2_TEXT[8 * (SCREEN_LEN - 1 - pos) +: 8]};
      return rs_byte;
   endfunction

   // --------------------
   // PS/2 pin decoder
   always @(negedge ps2_clk or negedge iRST_N)
   begin
      if (!iRST_N)
         ps2_cnt = 0;
      else if (ps2_cnt == 0)
      begin
         if (!ps2_data)                   // Start bit
            ps2_cnt = 1;
      end
      else if (ps2_cnt <= SCAN_W)
      begin
         ps2_code[ps2_cnt-1] = ps2_data;  // LSB first
         ps2_cnt++;
      end
      else if (ps2_cnt == SCAN_W + 1)
         ps2_cnt++;                       // Parity ignored
      else
      begin
         last_code = ps2_code;            // Stop bit
         key_total++;
         ps2_cnt = 0;
      end
   end

   // --------------------
   // LCD byte compare on each latch edge
   always @(negedge lcd_en or negedge iRST_N)
   begin
      logic [CHAR_W:0] exp;
      logic            key_slot;
      if (!iRST_N)
      begin
         byte_idx  = 0;                   // Stream restarts with init
         shown_key = 8'h30;
         allow_old = 1'b0;
         keys_used = key_total;
      end
      else
      begin
         if (keys_used != key_total)      // New key since last byte
         begin
            old_key   = shown_key;
            shown_key = expected_key(last_code);
            allow_old = 1'b1;
            keys_used = key_total;
         end
         exp      = expected_byte(byte_idx, shown_key);
         key_slot = (byte_idx >= INIT_LEN) && ((byte_idx - INIT_LEN) % REFRESH_LEN == KEY_POS);
         if (lcd_rs !== exp[CHAR_W])
         begin
            byte_errors++;
            $display("ERR lcd_rs byte %0d: expected %h, actual %h", byte_idx, exp[CHAR_W],
                     lcd_rs);
         end
         if (lcd_data !== exp[CHAR_W-1:0] && !(key_slot && allow_old && lcd_data === old_key))
         begin
            byte_errors++;
            $display("ERR lcd_data byte %0d: expected %h, actual %h", byte_idx,
                     exp[CHAR_W-1:0], lcd_data);
         end
         if (key_slot || exp === {1'b0, CMD_HOME})
            allow_old = 1'b0;             // Old key only within the refresh in progress
         byte_idx++;
         byte_total++;
      end
   end

   // Strobe activity, sampled away from the DUT edge
   always @(negedge clock)
   begin
      if (!iRST_N || (en_d && !lcd_en))
         idle_cycles <= 0;
      else
      begin
         idle_cycles <= idle_cycles + 1;
         if (idle_cycles == STALL_LIMIT)
         begin
            stall_errors <= stall_errors + 1;
            $display("No falling edge on lcd_en for %0d clock cycles", STALL_LIMIT);
         end
      end
      en_d <= lcd_en;
   end

endmodule

// ==== tb_ps2_lcd.sv ====
`timescale 1ns/10ps
module tb_ps2_lcd;
   import ps2_lcd_pkg::*;

   localparam int CLK_PERIOD     = 4;
   localparam int TICK_DIV       = 12;
   localparam int HALF_BIT       = 40;                   // Cycles per PS/2 half bit
   localparam int REFRESH_CYCLES = (SCREEN_LEN + 2) * 3 * TICK_DIV;
   localparam int GAP_CYCLES     = REFRESH_CYCLES + 80;  // Idle after each frame
   localparam int N_RANDOM       = 8;
   localparam int N_KEYS         = 4 + N_RANDOM + 1;     // Fixed, random, after reset

   logic              clock;
   logic              iRST_N;
   logic              ps2_clk;
   logic              ps2_data;
   logic              lcd_en;
   logic              lcd_rs;
   logic [CHAR_W-1:0] lcd_data;
   int                error_count;
   int                bytes_checked;
   int                keys_seen;
   int                keys_sent;
   logic [31:0]       lfsr;

   // Mapped keys with a few unmapped codes mixed in
   logic [SCAN_W-1:0] key_list [16] = '{8'h1C, 8'h32, 8'h4D, 8'h1A, 8'h35, 8'h45, 8'h16,
      8'h46, 8'h70, 8'h69, 8'h7D, 8'h2E, 8'h73, 8'hF0, 8'h29, 8'h5A};

   ps2_lcd_top #(.TICK_DIV(TICK_DIV), .FILTER_LEN(8)) i_ps2_lcd_top (
      .clock(clock), .iRST_N(iRST_N), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_data(lcd_data));

   ps2_lcd_checker #(.TICK_DIV(TICK_DIV)) i_ps2_lcd_checker (
      .clock(clock), .iRST_N(iRST_N), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_data(lcd_data),
      .error_count(error_count), .bytes_checked(bytes_checked), .keys_seen(keys_seen));

   bind ps2_lcd_top ps2_lcd_asserts i_ps2_lcd_asserts (
      .clock(clock), .iRST_N(iRST_N), .key_req(key_req), .key_ack(key_ack),
      .scan_code(scan_code), .lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_data(lcd_data),
      .seq_state(i_lcd_sequencer.state));

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clock);
      #1;                                 // Drive just after the edge
   endtask

   task automatic random_key(output logic [SCAN_W-1:0] code);
      logic [3:0] idx;
      for (int i = 0; i < 4; i++)
      begin
         idx[i] = lfsr[0];                // One step per bit taken
         lfsr   = lfsr_next(lfsr);
      end
      code = key_list[idx];
   endtask

   // --------------------
   // PS/2 frame driver
   task automatic send_key(input logic [SCAN_W-1:0] code);
      logic [10:0] frame;
      frame = {1'b1, ~^code, code, 1'b0}; // Stop, odd parity, data, start
      for (int i = 0; i < 11; i++)
      begin
         ps2_data = frame[i];             // Data changes while clock high
         wait_cycles(HALF_BIT);
         ps2_clk = 1'b0;
         wait_cycles(HALF_BIT);
         ps2_clk = 1'b1;
      end
      ps2_data = 1'b1;
      keys_sent++;
      wait_cycles(GAP_CYCLES);            // Key reaches the screen
   endtask

   task automatic finish_run();
      int total;
      total = error_count + i_ps2_lcd_top.i_ps2_lcd_asserts.fail_count;
      if (keys_seen != keys_sent)
      begin
         $display("Checker decoded %0d keys but %0d were sent", keys_seen, keys_sent);
         total++;
      end
      $display("Errors: %0d (checker %0d, assertions %0d), LCD bytes checked: %0d", total,
               error_count, i_ps2_lcd_top.i_ps2_lcd_asserts.fail_count, bytes_checked);
      if (total == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   endtask

   initial
   begin
      clock = 1'b0;
      forever #(CLK_PERIOD / 2) clock = ~clock;
   end

   // --------------------
   // Stimulus
   initial
   begin
      logic [SCAN_W-1:0] code;
      iRST_N    = 1'b0;
      ps2_clk   = 1'b1;                   // Lines idle high
      ps2_data  = 1'b1;
      keys_sent = 0;
      lfsr      = 32'h1c34_6664;
      wait_cycles(2);
      iRST_N = 1'b1;
      wait_cycles(GAP_CYCLES);            // Init commands and a clean refresh
      send_key(8'h16);                    // Top row 1
      send_key(8'h69);                    // Keypad 1
      send_key(8'h1C);                    // A
      send_key(8'hF0);                    // Break prefix, unmapped
      for (int i = 0; i < N_RANDOM; i++)
      begin
         random_key(code);
         send_key(code);
      end
      iRST_N = 1'b0;                      // Mid-run reset
      wait_cycles(2);
      iRST_N = 1'b1;
      wait_cycles(GAP_CYCLES);            // KEY_POS back to '0'
      send_key(8'h2B);                    // F
      wait_cycles(REFRESH_CYCLES);
      finish_run();
   end

   // Watchdog
   initial
   begin
      #((N_KEYS + 2) * REFRESH_CYCLES * 2 * CLK_PERIOD);
      $display("Watchdog expired before the test sequence finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
ps2_lcd_pkg.sv
ps2_receiver.sv
scan_decoder.sv
lcd_screen_text.sv
lcd_sequencer.sv
ps2_lcd_top.sv
ps2_lcd_asserts.sv
ps2_lcd_checker.sv
tb_ps2_lcd.sv

// ==== Makefile ====
# Verilator flow for the PS/2 to LCD project
VERILATOR  ?= verilator
TOP        ?= tb_ps2_lcd
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
RUN_ARGS   ?= +verilator+error+limit+1000
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL, run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
